//--- hwce_defs.svh
// --------------------------------------------------------------------------
// bus widths, buffer depth and fixed-point shift of the convolution engine
// include in every module that sizes a port or a register from these
// --------------------------------------------------------------------------

`ifndef HWCE_DEFS_SVH
`define HWCE_DEFS_SVH

// cluster bus
`define HWCE_ADDR_W      32
`define HWCE_DATA_W      32
`define HWCE_BE_W        (`HWCE_DATA_W / 8)

// peripheral config slave
`define HWCE_ID_W        8
`define HWCE_CFG_ADDR_W  11

// input buffer, words between source and engine
`define HWCE_FIFO_DEPTH  4
`define HWCE_CNT_W       ($clog2(`HWCE_FIFO_DEPTH + 1))

// arithmetic right shift applied to each filter sum
`define HWCE_QF          4

`endif

//--- hwce_pkg.sv
// --------------------------------------------------------------------------
// shared types of the convolution engine
// register map index and the state of the streaming blocks
// --------------------------------------------------------------------------

package hwce_pkg;

   // register index, taken from cfg address bits 4..2
   typedef enum logic [2:0] {
      REG_SRC_ADDR = 3'd0,  // source vector base
      REG_DST_ADDR = 3'd1,  // result vector base
      REG_LEN      = 3'd2,  // number of outputs, 16 bits
      REG_WEIGHTS  = 3'd3,  // w0 7..0, w1 15..8, w2 23..16
      REG_TRIGGER  = 3'd4,  // any write starts a job
      REG_STATUS   = 3'd5   // bit 0 busy
   } hwce_reg_e;

   // shared by source streamer and conv engine
   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_RUN  = 1'b1
   } hwce_stream_state_e;

endpackage

//--- hwce_cfg_regs.sv
// --------------------------------------------------------------------------
// configuration slave of the engine: job registers, trigger and status
// grant in the request cycle, response with echoed ID one cycle later
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "hwce_defs.svh"

module hwce_cfg_regs
   import hwce_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        cfg_req_i,
   input  logic [`HWCE_CFG_ADDR_W-1:0] cfg_add_i,
   input  logic                        cfg_wen_i,      // 0 is write
   input  logic [`HWCE_BE_W-1:0]       cfg_be_i,
   input  logic [`HWCE_DATA_W-1:0]     cfg_wdata_i,
   input  logic [`HWCE_ID_W-1:0]       cfg_id_i,
   output logic                        cfg_gnt_o,
   output logic                        cfg_r_valid_o,
   output logic [`HWCE_DATA_W-1:0]     cfg_r_rdata_o,
   output logic [`HWCE_ID_W-1:0]       cfg_r_id_o,
   input  logic                        job_done_i,
   output logic                        job_start_o,
   output logic [`HWCE_ADDR_W-1:0]     src_addr_o,
   output logic [`HWCE_ADDR_W-1:0]     dst_addr_o,
   output logic [15:0]                 len_o,
   output logic [23:0]                 weights_o,
   output logic                        evt_interrupt_o
);

   hwce_reg_e                 reg_idx;
   logic                      wr_en;
   logic                      start;
   logic                      busy_q;
   logic [`HWCE_DATA_W-1:0]   rdata;
   logic [`HWCE_DATA_W-1:0]   merged;

   assign reg_idx   = hwce_reg_e'(cfg_add_i[4:2]);
   assign cfg_gnt_o = cfg_req_i;                        // always ready
   assign wr_en     = cfg_req_i & ~cfg_wen_i & ~busy_q; // job regs frozen while busy
   assign start     = wr_en && (reg_idx == REG_TRIGGER) && (len_o != 16'd0);

   // current value of the addressed register, also the read data
   always_comb begin
      case (reg_idx)
         REG_SRC_ADDR: rdata = src_addr_o;
         REG_DST_ADDR: rdata = dst_addr_o;
         REG_LEN:      rdata = {16'd0, len_o};
         REG_WEIGHTS:  rdata = {8'd0, weights_o};
         REG_STATUS:   rdata = {31'd0, busy_q};
         default:      rdata = '0;            // trigger reads as zero
      endcase
   end

   // byte enable merge of write data over the old value
   always_comb begin
      for (int b = 0; b < `HWCE_BE_W; b++) begin
         merged[8*b +: 8] = cfg_be_i[b] ? cfg_wdata_i[8*b +: 8] : rdata[8*b +: 8];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         src_addr_o      <= '0;
         dst_addr_o      <= '0;
         len_o           <= '0;
         weights_o       <= '0;
         busy_q          <= 1'b0;
         job_start_o     <= 1'b0;
         evt_interrupt_o <= 1'b0;
         cfg_r_valid_o   <= 1'b0;
      end else begin
         cfg_r_valid_o   <= cfg_req_i;
         job_start_o     <= start;
         evt_interrupt_o <= job_done_i;   // end of job event
         if (wr_en) begin
            case (reg_idx)
               REG_SRC_ADDR: src_addr_o <= merged;
               REG_DST_ADDR: dst_addr_o <= merged;
               REG_LEN:      len_o      <= merged[15:0];
               REG_WEIGHTS:  weights_o  <= merged[23:0];
               default:      ;
            endcase
         end
         if (start) begin
            busy_q <= 1'b1;
         end else if (job_done_i) begin
            busy_q <= 1'b0;
         end
      end
   end

   // response payload
   always_ff @(posedge clk_i) begin
      if (cfg_req_i) begin
         cfg_r_rdata_o <= rdata;
         cfg_r_id_o    <= cfg_id_i;
      end
   end

   // a new job only starts once the previous one has ended
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      job_start_o |-> !$past(busy_q));
   // engine reports done only for a running job
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      job_done_i |-> busy_q && !job_start_o);

endmodule

//--- hwce_source.sv
// --------------------------------------------------------------------------
// load streamer, reads N+2 words from the source vector over port 0
// and pushes every returned word into the input buffer
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "hwce_defs.svh"

module hwce_source
   import hwce_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    job_start_i,
   input  logic [`HWCE_ADDR_W-1:0] src_addr_i,
   input  logic [15:0]             len_i,
   input  logic [`HWCE_CNT_W-1:0]  fifo_count_i,
   output logic                    ld_req_o,
   output logic [`HWCE_ADDR_W-1:0] ld_add_o,
   output logic                    ld_wen_o,
   output logic [`HWCE_BE_W-1:0]   ld_be_o,
   input  logic                    ld_gnt_i,
   input  logic                    ld_r_valid_i,
   input  logic [`HWCE_DATA_W-1:0] ld_r_rdata_i,
   output logic                    push_o,
   output logic [`HWCE_DATA_W-1:0] push_data_o
);

   localparam logic [`HWCE_CNT_W:0] DEPTH = `HWCE_FIFO_DEPTH;

   hwce_stream_state_e        state_q;
   logic [16:0]               issued_q;
   logic [16:0]               total;
   logic [`HWCE_CNT_W-1:0]    inflight_q;   // granted, data not back yet
   logic                      credit_ok;
   logic                      grant;

   assign total     = {1'b0, len_i} + 17'd2;   // 3-tap window needs two extra words
   assign credit_ok = ({1'b0, fifo_count_i} + {1'b0, inflight_q}) < DEPTH;

   // credits only grow through our own grants, so req stays up until gnt
   assign ld_req_o  = (state_q == ST_RUN) && credit_ok;
   assign ld_wen_o  = 1'b1;
   assign ld_be_o   = '1;
   assign grant     = ld_req_o & ld_gnt_i;

   // load data is one cycle behind the grant, pushed as it arrives
   assign push_o      = ld_r_valid_i;
   assign push_data_o = ld_r_rdata_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         issued_q   <= '0;
         inflight_q <= '0;
         ld_add_o   <= '0;
      end else begin
         if (job_start_i) begin
            state_q  <= ST_RUN;
            issued_q <= '0;
            ld_add_o <= src_addr_i;
         end else if (grant) begin
            issued_q <= issued_q + 17'd1;
            ld_add_o <= ld_add_o + `HWCE_ADDR_W'(4);
            if (issued_q == total - 17'd1) begin
               state_q <= ST_IDLE;   // last read issued
            end
         end
         case ({grant, ld_r_valid_i})
            2'b10:   inflight_q <= inflight_q + 1'b1;
            2'b01:   inflight_q <= inflight_q - 1'b1;
            default: ;
         endcase
      end
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ld_req_o && !ld_gnt_i |=> ld_req_o && $stable(ld_add_o));

endmodule

//--- hwce_fifo.sv
// --------------------------------------------------------------------------
// synchronous input buffer between load streamer and conv engine
// head word is visible while not empty, pop consumes it in the same cycle
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "hwce_defs.svh"

module hwce_fifo (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    push_i,
   input  logic [`HWCE_DATA_W-1:0] push_data_i,
   input  logic                    pop_i,
   output logic [`HWCE_DATA_W-1:0] head_o,
   output logic                    empty_o,
   output logic [`HWCE_CNT_W-1:0]  count_o
);

   localparam int PTR_W = $clog2(`HWCE_FIFO_DEPTH);

   logic [`HWCE_DATA_W-1:0] mem [`HWCE_FIFO_DEPTH];
   logic [PTR_W-1:0]        wr_ptr_q;   // power of two depth, pointers wrap
   logic [PTR_W-1:0]        rd_ptr_q;

   assign head_o  = mem[rd_ptr_q];
   assign empty_o = (count_o == '0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_o  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push_i && !pop_i) begin
            count_o <= count_o + 1'b1;
         end else if (pop_i && !push_i) begin
            count_o <= count_o - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) mem[wr_ptr_q] <= push_data_i;
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> count_o < `HWCE_CNT_W'(`HWCE_FIFO_DEPTH));
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

//--- hwce_conv_engine.sv
// --------------------------------------------------------------------------
// 3-tap signed filter, pops input words into a window and stores one
// result per window over port 1, job_done on the grant of the last store
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "hwce_defs.svh"

module hwce_conv_engine
   import hwce_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    job_start_i,
   input  logic [`HWCE_ADDR_W-1:0] dst_addr_i,
   input  logic [15:0]             len_i,
   input  logic [23:0]             weights_i,
   input  logic [`HWCE_DATA_W-1:0] head_i,
   input  logic                    empty_i,
   output logic                    pop_o,
   output logic                    st_req_o,
   output logic [`HWCE_ADDR_W-1:0] st_add_o,
   output logic                    st_wen_o,
   output logic [`HWCE_BE_W-1:0]   st_be_o,
   output logic [`HWCE_DATA_W-1:0] st_wdata_o,
   input  logic                    st_gnt_i,
   output logic                    job_done_o
);

   hwce_stream_state_e        state_q;
   logic signed [31:0]        x0_q;          // oldest sample, x[k]
   logic signed [31:0]        x1_q;
   logic signed [31:0]        x2_q;
   logic [1:0]                fill_q;        // valid words in window
   logic [15:0]               out_cnt_q;
   logic signed [7:0]         w0;
   logic signed [7:0]         w1;
   logic signed [7:0]         w2;
   logic signed [47:0]        sum;
   logic signed [47:0]        sum_sh;
   logic                      fire;
   logic                      grant;

   assign w0 = weights_i[7:0];
   assign w1 = weights_i[15:8];
   assign w2 = weights_i[23:16];

   // operands sign extended to 48 bits before the multiply
   assign sum    = x0_q * w0 + x1_q * w1 + x2_q * w2;
   assign sum_sh = sum >>> `HWCE_QF;

   // no pop while a store is waiting for its grant
   assign pop_o = (state_q == ST_RUN) && !st_req_o && (fill_q != 2'd3) && !empty_i;
   assign fire  = (state_q == ST_RUN) && !st_req_o && (fill_q == 2'd3);
   assign grant = st_req_o & st_gnt_i;

   assign job_done_o = grant && ((out_cnt_q + 16'd1) == len_i);
   assign st_wen_o   = 1'b0;   // write
   assign st_be_o    = '1;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_IDLE;
         fill_q    <= '0;
         out_cnt_q <= '0;
         st_req_o  <= 1'b0;
      end else begin
         if (job_start_i) begin
            state_q   <= ST_RUN;
            fill_q    <= '0;
            out_cnt_q <= '0;
         end else if (pop_o) begin
            fill_q <= fill_q + 2'd1;
         end else if (fire) begin
            st_req_o <= 1'b1;
         end else if (grant) begin
            st_req_o  <= 1'b0;
            fill_q    <= 2'd2;            // slide by one sample
            out_cnt_q <= out_cnt_q + 16'd1;
            if (job_done_o) state_q <= ST_IDLE;
         end
      end
   end

   // window and store payload
   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         x0_q <= x1_q;
         x1_q <= x2_q;
         x2_q <= head_i;
      end
      if (fire) begin
         st_wdata_o <= sum_sh[31:0];
         st_add_o   <= dst_addr_i + {14'd0, out_cnt_q, 2'b00};   // y[k] at dst + 4k
      end
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      st_req_o && !st_gnt_i |=> st_req_o && $stable(st_add_o) && $stable(st_wdata_o));

endmodule

//--- hwce_wrap.sv
// --------------------------------------------------------------------------
// top of the convolution accelerator, cfg slave plus two master ports
// port 0 loads the source vector, port 1 stores the filtered results
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "hwce_defs.svh"

module hwce_wrap (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // peripheral config slave
   input  logic                        cfg_req_i,
   input  logic [`HWCE_CFG_ADDR_W-1:0] cfg_add_i,
   input  logic                        cfg_wen_i,
   input  logic [`HWCE_BE_W-1:0]       cfg_be_i,
   input  logic [`HWCE_DATA_W-1:0]     cfg_wdata_i,
   input  logic [`HWCE_ID_W-1:0]       cfg_id_i,
   output logic                        cfg_gnt_o,
   output logic                        cfg_r_valid_o,
   output logic [`HWCE_DATA_W-1:0]     cfg_r_rdata_o,
   output logic [`HWCE_ID_W-1:0]       cfg_r_id_o,
   // master port 0, loads
   output logic                        ld_req_o,
   output logic [`HWCE_ADDR_W-1:0]     ld_add_o,
   output logic                        ld_wen_o,
   output logic [`HWCE_BE_W-1:0]       ld_be_o,
   output logic [`HWCE_DATA_W-1:0]     ld_wdata_o,
   input  logic                        ld_gnt_i,
   input  logic                        ld_r_valid_i,
   input  logic [`HWCE_DATA_W-1:0]     ld_r_rdata_i,
   // master port 1, stores
   output logic                        st_req_o,
   output logic [`HWCE_ADDR_W-1:0]     st_add_o,
   output logic                        st_wen_o,
   output logic [`HWCE_BE_W-1:0]       st_be_o,
   output logic [`HWCE_DATA_W-1:0]     st_wdata_o,
   input  logic                        st_gnt_i,
   input  logic                        st_r_valid_i,   // store responses unused
   input  logic [`HWCE_DATA_W-1:0]     st_r_rdata_i,
   // event line
   output logic                        evt_interrupt_o
);

   logic                      job_start;
   logic                      job_done;
   logic [`HWCE_ADDR_W-1:0]   src_addr;
   logic [`HWCE_ADDR_W-1:0]   dst_addr;
   logic [15:0]               len;
   logic [23:0]               weights;
   logic                      push;
   logic [`HWCE_DATA_W-1:0]   push_data;
   logic                      pop;
   logic [`HWCE_DATA_W-1:0]   head;
   logic                      empty;
   logic [`HWCE_CNT_W-1:0]    fifo_count;

   assign ld_wdata_o = '0;   // load port never writes

   hwce_cfg_regs u_cfg_regs (
      .clk_i           ( clk_i           ),
      .rst_n_i         ( rst_n_i         ),
      .cfg_req_i       ( cfg_req_i       ),
      .cfg_add_i       ( cfg_add_i       ),
      .cfg_wen_i       ( cfg_wen_i       ),
      .cfg_be_i        ( cfg_be_i        ),
      .cfg_wdata_i     ( cfg_wdata_i     ),
      .cfg_id_i        ( cfg_id_i        ),
      .cfg_gnt_o       ( cfg_gnt_o       ),
      .cfg_r_valid_o   ( cfg_r_valid_o   ),
      .cfg_r_rdata_o   ( cfg_r_rdata_o   ),
      .cfg_r_id_o      ( cfg_r_id_o      ),
      .job_done_i      ( job_done        ),
      .job_start_o     ( job_start       ),
      .src_addr_o      ( src_addr        ),
      .dst_addr_o      ( dst_addr        ),
      .len_o           ( len             ),
      .weights_o       ( weights         ),
      .evt_interrupt_o ( evt_interrupt_o )
   );

   hwce_source u_source (
      .clk_i           ( clk_i           ),
      .rst_n_i         ( rst_n_i         ),
      .job_start_i     ( job_start       ),
      .src_addr_i      ( src_addr        ),
      .len_i           ( len             ),
      .fifo_count_i    ( fifo_count      ),
      .ld_req_o        ( ld_req_o        ),
      .ld_add_o        ( ld_add_o        ),
      .ld_wen_o        ( ld_wen_o        ),
      .ld_be_o         ( ld_be_o         ),
      .ld_gnt_i        ( ld_gnt_i        ),
      .ld_r_valid_i    ( ld_r_valid_i    ),
      .ld_r_rdata_i    ( ld_r_rdata_i    ),
      .push_o          ( push            ),
      .push_data_o     ( push_data       )
   );

   hwce_fifo u_fifo (
      .clk_i           ( clk_i           ),
      .rst_n_i         ( rst_n_i         ),
      .push_i          ( push            ),
      .push_data_i     ( push_data       ),
      .pop_i           ( pop             ),
      .head_o          ( head            ),
      .empty_o         ( empty           ),
      .count_o         ( fifo_count      )
   );

   hwce_conv_engine u_conv_engine (
      .clk_i           ( clk_i           ),
      .rst_n_i         ( rst_n_i         ),
      .job_start_i     ( job_start       ),
      .dst_addr_i      ( dst_addr        ),
      .len_i           ( len             ),
      .weights_i       ( weights         ),
      .head_i          ( head            ),
      .empty_i         ( empty           ),
      .pop_o           ( pop             ),
      .st_req_o        ( st_req_o        ),
      .st_add_o        ( st_add_o        ),
      .st_wen_o        ( st_wen_o        ),
      .st_be_o         ( st_be_o         ),
      .st_wdata_o      ( st_wdata_o      ),
      .st_gnt_i        ( st_gnt_i        ),
      .job_done_o      ( job_done        )
   );

endmodule

//--- tb_clk_gen.sv
// --------------------------------------------------------------------------
// free running testbench clock, 50 ns high and 50 ns low by default
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- tb_hwce_wrap.sv
// --------------------------------------------------------------------------
// testbench of the convolution accelerator: memory model on both master
// ports, config bus driver, reference filter and a full memory compare
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "hwce_defs.svh"

module tb_hwce_wrap
   import hwce_pkg::*;
;

   localparam int MEM_WORDS   = 1024;
   localparam int JOB_TIMEOUT = 4000;   // cycles

   logic                        clk_i;
   logic                        rst_n_i;
   logic                        cfg_req_i;
   logic [`HWCE_CFG_ADDR_W-1:0] cfg_add_i;
   logic                        cfg_wen_i;
   logic [`HWCE_BE_W-1:0]       cfg_be_i;
   logic [`HWCE_DATA_W-1:0]     cfg_wdata_i;
   logic [`HWCE_ID_W-1:0]       cfg_id_i;
   logic                        cfg_gnt_o;
   logic                        cfg_r_valid_o;
   logic [`HWCE_DATA_W-1:0]     cfg_r_rdata_o;
   logic [`HWCE_ID_W-1:0]       cfg_r_id_o;
   logic                        ld_req_o;
   logic [`HWCE_ADDR_W-1:0]     ld_add_o;
   logic                        ld_wen_o;
   logic [`HWCE_BE_W-1:0]       ld_be_o;
   logic [`HWCE_DATA_W-1:0]     ld_wdata_o;
   logic                        ld_gnt_i = 1'b0;
   logic                        ld_r_valid_i = 1'b0;
   logic [`HWCE_DATA_W-1:0]     ld_r_rdata_i = '0;
   logic                        st_req_o;
   logic [`HWCE_ADDR_W-1:0]     st_add_o;
   logic                        st_wen_o;
   logic [`HWCE_BE_W-1:0]       st_be_o;
   logic [`HWCE_DATA_W-1:0]     st_wdata_o;
   logic                        st_gnt_i = 1'b0;
   logic                        st_r_valid_i = 1'b0;   // store responses unused
   logic [`HWCE_DATA_W-1:0]     st_r_rdata_i = '0;
   logic                        evt_interrupt_o;

   logic [31:0] mem [MEM_WORDS];       // memory behind both ports
   logic [31:0] exp_mem [MEM_WORDS];   // expected memory image
   logic [31:0] reg_mdl [8];
   logic        busy_mdl = 1'b0;
   int          seed = 32'hecea;       // stimulus
   int          mem_seed = 32'hecea;   // memory fill and grant stalls
   int          ld_wait = 0;
   int          st_wait = 0;
   int          st_stall_max = 3;
   int          evt_count = 0;
   int          errors = 0;
   int          jobs = 0;
   logic        aborted = 1'b0;
   int          n;
   int          evt_before;

   tb_clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk_o(clk_i));

   hwce_wrap u_hwce_wrap (.*);

   // memory model, registered grants after a random stall, data one cycle later
   always @(posedge clk_i) begin
      ld_gnt_i     <= 1'b0;
      ld_r_valid_i <= 1'b0;
      st_gnt_i     <= 1'b0;
      if (!rst_n_i) begin
         for (int i = 0; i < MEM_WORDS; i++) mem[i] <= $random(mem_seed);
         ld_wait <= 0;
         st_wait <= 0;
      end else begin
         if (ld_req_o && ld_gnt_i) begin
            // read, all bytes, nothing driven on the write data
            if (ld_wen_o !== 1'b1 || ld_be_o !== '1 || ld_wdata_o !== '0) begin
               log_error($sformatf("load with wen %b be %h wdata %h", ld_wen_o, ld_be_o,
                                   ld_wdata_o));
            end
            ld_r_valid_i <= 1'b1;
            ld_r_rdata_i <= mem[ld_add_o[11:2]];
            ld_wait      <= $unsigned($random(mem_seed)) % 4;
         end else if (ld_req_o) begin
            if (ld_wait == 0) ld_gnt_i <= 1'b1;
            else ld_wait <= ld_wait - 1;
         end
         if (st_req_o && st_gnt_i) begin
            if (st_wen_o !== 1'b0 || st_be_o !== '1) begin
               log_error($sformatf("store with wen %b be %h", st_wen_o, st_be_o));
            end
            mem[st_add_o[11:2]] <= st_wdata_o;
            st_wait <= $unsigned($random(mem_seed)) % (st_stall_max + 1);
         end else if (st_req_o) begin
            if (st_wait == 0) st_gnt_i <= 1'b1;
            else st_wait <= st_wait - 1;
         end
      end
   end

   always @(posedge clk_i) begin
      if (rst_n_i && evt_interrupt_o) evt_count <= evt_count + 1;   // one per high cycle
   end

   task automatic log_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      errors++;
   endtask

   // y = (w0*x0 + w1*x1 + w2*x2) >>> QF, 48-bit sum, low word kept
   function automatic logic [31:0] filter_word(input logic [31:0] x0, input logic [31:0] x1,
                                               input logic [31:0] x2, input logic [23:0] w);
      logic signed [47:0] s0, s1, s2, c0, c1, c2, acc;
      s0  = $signed(x0);
      s1  = $signed(x1);
      s2  = $signed(x2);
      c0  = $signed(w[7:0]);
      c1  = $signed(w[15:8]);
      c2  = $signed(w[23:16]);
      acc = s0 * c0 + s1 * c1 + s2 * c2;
      acc = acc >>> `HWCE_QF;
      return acc[31:0];
   endfunction

   function automatic logic [31:0] reg_value(input hwce_reg_e idx);
      case (idx)
         REG_STATUS:  return {31'd0, busy_mdl};
         REG_TRIGGER: return 32'd0;
         default:     return reg_mdl[idx];
      endcase
   endfunction

   // register file model, nothing changes while a job runs
   function automatic void model_write(input hwce_reg_e idx, input logic [3:0] be,
                                       input logic [31:0] d);
      logic [31:0] m;
      m = reg_mdl[idx];
      for (int b = 0; b < 4; b++) begin
         if (be[b]) m[8*b +: 8] = d[8*b +: 8];
      end
      if (!busy_mdl) begin
         case (idx)
            REG_SRC_ADDR, REG_DST_ADDR: reg_mdl[idx] = m;
            REG_LEN:     reg_mdl[idx] = m & 32'h0000_ffff;
            REG_WEIGHTS: reg_mdl[idx] = m & 32'h00ff_ffff;
            REG_TRIGGER: busy_mdl = (reg_mdl[REG_LEN] != 32'd0);   // N of 0 is ignored
            default:     ;
         endcase
      end
   endfunction

   // one config access, grant in the request cycle, response one cycle later
   task automatic cfg_access(input logic wr, input hwce_reg_e idx, input logic [3:0] be,
                             input logic [31:0] wdata);
      logic [7:0]  id;
      logic [31:0] exp_rd;
      id     = 8'($random(seed));
      exp_rd = reg_value(idx);
      @(posedge clk_i);
      cfg_req_i   <= 1'b1;
      cfg_add_i   <= {6'd0, idx, 2'b00};
      cfg_wen_i   <= ~wr;
      cfg_be_i    <= be;
      cfg_wdata_i <= wdata;
      cfg_id_i    <= id;
      @(posedge clk_i);
      cfg_req_i <= 1'b0;
      if (cfg_gnt_o !== 1'b1) log_error("config grant missing in request cycle");
      if (cfg_r_valid_o !== 1'b0) log_error("config response in request cycle");
      if (wr) model_write(idx, be, wdata);
      @(posedge clk_i);
      if (cfg_r_valid_o !== 1'b1) log_error("config r_valid missing one cycle after request");
      if (cfg_r_id_o !== id) log_error($sformatf("r_id %h, expected %h", cfg_r_id_o, id));
      if (!wr && cfg_r_rdata_o !== exp_rd) begin
         log_error($sformatf("%s reads %h, expected %h", idx.name(), cfg_r_rdata_o, exp_rd));
      end
   endtask

   task automatic wait_event(input int target);
      int cycles;
      cycles = 0;
      while (evt_count < target && cycles < JOB_TIMEOUT) begin
         @(posedge clk_i);
         cycles++;
      end
      if (evt_count < target) begin
         $display("timeout: no end of job event within %0d cycles", JOB_TIMEOUT);
         errors++;
         aborted = 1'b1;
      end
      busy_mdl = 1'b0;
   endtask

   task automatic compare_mem();
      for (int i = 0; i < MEM_WORDS; i++) begin
         if (mem[i] !== exp_mem[i]) begin
            log_error($sformatf("word %0d is %h, expected %h", i, mem[i], exp_mem[i]));
         end
      end
   endtask

   // one filter job, optionally with ignored writes while it is busy
   task automatic run_job(input int len, input int stall_max, input logic guard);
      int          src_w;
      int          dst_w;
      int          target;
      logic [23:0] w;
      src_w        = 16 + ($unsigned($random(seed)) % 200);
      dst_w        = 512 + ($unsigned($random(seed)) % 200);
      w            = 24'($random(seed));
      st_stall_max = stall_max;
      cfg_access(1'b1, REG_SRC_ADDR, 4'hf, 32'(src_w * 4));
      cfg_access(1'b1, REG_DST_ADDR, 4'hf, 32'(dst_w * 4));
      cfg_access(1'b1, REG_LEN, 4'hf, 32'(len));
      cfg_access(1'b1, REG_WEIGHTS, 4'hf, {8'hff, w});
      for (int k = 0; k < len; k++) begin
         exp_mem[dst_w + k] = filter_word(exp_mem[src_w + k], exp_mem[src_w + k + 1],
                                          exp_mem[src_w + k + 2], w);
      end
      target = evt_count + 1;
      cfg_access(1'b1, REG_TRIGGER, 4'hf, 32'h1);
      cfg_access(1'b0, REG_STATUS, 4'hf, 32'h0);   // busy expected
      if (guard) begin
         cfg_access(1'b1, REG_TRIGGER, 4'hf, 32'h1);
         cfg_access(1'b1, REG_SRC_ADDR, 4'hf, $random(seed));
         cfg_access(1'b1, REG_LEN, 4'h3, $random(seed));
         cfg_access(1'b1, REG_WEIGHTS, 4'hf, $random(seed));
      end
      wait_event(target);
      if (!aborted) begin
         repeat (20) @(posedge clk_i);
         if (evt_count != target) log_error($sformatf("%0d events after job", evt_count));
         for (int r = 0; r < 6; r++) cfg_access(1'b0, hwce_reg_e'(r), 4'hf, 32'h0);
         compare_mem();
         jobs++;
      end
   endtask

   initial begin
      cfg_req_i   <= 1'b0;
      cfg_add_i   <= '0;
      cfg_wen_i   <= 1'b1;
      cfg_be_i    <= '0;
      cfg_wdata_i <= '0;
      cfg_id_i    <= '0;
      rst_n_i     <= 1'b0;
      for (int i = 0; i < 8; i++) reg_mdl[i] = 32'd0;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      for (int i = 0; i < MEM_WORDS; i++) exp_mem[i] = mem[i];
      if (ld_req_o || st_req_o || evt_interrupt_o) log_error("request or event high after reset");

      // register access with mixed byte enables
      for (int r = 0; r < 12; r++) begin
         cfg_access(1'b1, hwce_reg_e'(r % 4), 4'($random(seed)), $random(seed));
      end
      for (int r = 0; r < 6; r++) cfg_access(1'b0, hwce_reg_e'(r), 4'hf, 32'h0);

      // trigger with N of 0 does nothing
      cfg_access(1'b1, REG_LEN, 4'hf, 32'h0);
      evt_before = evt_count;
      cfg_access(1'b1, REG_TRIGGER, 4'hf, 32'h1);
      cfg_access(1'b0, REG_STATUS, 4'hf, 32'h0);
      repeat (40) @(posedge clk_i);
      if (evt_count != evt_before) log_error("event after a trigger with N of 0");
      compare_mem();

      for (int j = 0; j < 8; j++) begin
         n = 1 + ($unsigned($random(seed)) % 12);
         if (!aborted) run_job(n, 3, 1'b0);
      end
      if (!aborted) run_job(12, 3, 1'b1);
      for (int j = 0; j < 3; j++) begin
         n = 1 + ($unsigned($random(seed)) % 12);
         if (!aborted) run_job(n, 15, 1'b0);   // long store stalls
      end

      $display("jobs run %0d, errors %0d", jobs, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+.
hwce_pkg.sv
hwce_cfg_regs.sv
hwce_source.sv
hwce_fifo.sv
hwce_conv_engine.sv
hwce_wrap.sv
tb_clk_gen.sv
tb_hwce_wrap.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module tb_hwce_wrap -o sim_hwce
./obj_dir/sim_hwce | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
